/* Bender.yml */
package:
  name: cpu_core

sources:
  - source/cpuPkg.sv
  - source/registerFile.sv
  - source/arithUnit.sv
  - source/datapath.sv
  - source/controlSequencer.sv
  - source/cpuCore.sv
  - target: test
    files:
      - test/cpuCoreTb.sv

/* compile.f */
source/cpuPkg.sv
source/registerFile.sv
source/arithUnit.sv
source/datapath.sv
source/controlSequencer.sv
source/cpuCore.sv
test/cpuCoreTb.sv

/* source/arithUnit.sv */
`timescale 1ns/1ps

module arithUnit
    import cpuPkg::*;
(
    input  logic [wordWidth-1:0]   yValue,
    input  logic [wordWidth-1:0]   busValue,
    input  logic [opWidth-1:0]     aluOp,
    input  logic                   incPc,
    output logic [2*wordWidth-1:0] result
);

    logic signed [wordWidth-1:0]   dividend;
    logic signed [wordWidth-1:0]   divisor;
    logic signed [2*wordWidth-1:0] product;
    logic        [wordWidth-1:0]   quotient;
    logic        [wordWidth-1:0]   remainder;

    assign dividend = yValue;   // rb
    assign divisor  = busValue; // rc
    assign product  = dividend * divisor; // signed, 64-bit context

    always_comb begin
        if (divisor == '0) begin
            quotient  = '1;
            remainder = dividend;
        end else begin
            quotient  = dividend / divisor;
            remainder = dividend % divisor;
        end
    end

    always_comb begin
        if (incPc) begin
            // pc increment wins over whatever op is on the lines
            result = {{wordWidth{1'b0}}, busValue + 1'b1};
        end else begin
            case (aluOp)
                opAdd, opAddi: begin
                    result = {{wordWidth{1'b0}}, yValue + busValue};
                end
                opSub: result = {{wordWidth{1'b0}}, yValue - busValue};
                opAnd: result = {{wordWidth{1'b0}}, yValue & busValue};
                opOr:  result = {{wordWidth{1'b0}}, yValue | busValue};
                opMul: result = product;
                opDiv: result = {remainder, quotient}; // hi gets remainder
                default: result = '0;
            endcase
        end
    end

endmodule

/* source/controlSequencer.sv */
`timescale 1ns/1ps

module controlSequencer
    import cpuPkg::*;
(
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [wordWidth-1:0]   irWord,
    input  logic                   memAck,
    output logic                   pcOut,
    output logic                   mdrOut,
    output logic                   zLowOut,
    output logic                   zHighOut,
    output logic                   hiOut,
    output logic                   loOut,
    output logic                   regOut,
    output logic                   constOut,
    output logic                   pcIn,
    output logic                   marIn,
    output logic                   mdrIn,
    output logic                   irIn,
    output logic                   yIn,
    output logic                   zIn,
    output logic                   regIn,
    output logic                   hiIn,
    output logic                   loIn,
    output logic                   incPc,
    output logic [opWidth-1:0]     aluOp,
    output logic                   memCapture,
    output logic [regSelWidth-1:0] regSel,
    output logic                   memReq,
    output logic                   memWrite,
    output logic                   halted
);

    logic [stateWidth-1:0] state;
    logic [stateWidth-1:0] nextState;
    logic [opWidth-1:0]    opcode;
    logic                  isAlu;
    logic                  isWide;
    logic                  isImm;
    logic                  isSt;

    assign opcode = irWord[opMsb:opLsb];
    assign isWide = (opcode == opMul) || (opcode == opDiv);
    assign isImm  = (opcode == opAddi);
    assign isSt   = (opcode == opSt);
    assign isAlu  = isWide || isImm || (opcode == opAdd) || (opcode == opSub)
                    || (opcode == opAnd) || (opcode == opOr);

    always_comb begin
        {pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut, regOut, constOut} = '0;
        {pcIn, marIn, mdrIn, irIn, yIn, zIn, regIn, hiIn, loIn} = '0;
        incPc      = 1'b0;
        memCapture = 1'b0;
        aluOp      = opNop;
        regSel     = irWord[raMsb:raLsb]; // ra unless a step says otherwise
        nextState  = state;
        case (state)
            stateT0: begin
                pcOut = 1'b1;
                marIn = 1'b1;
                incPc = 1'b1;
                zIn   = 1'b1;
                nextState = stateT1;
            end
            stateT1: begin
                zLowOut   = 1'b1;
                pcIn      = 1'b1;
                nextState = stateFetchWait; // memReq rises on this edge
            end
            stateFetchWait: begin
                if (memAck) begin
                    memCapture = !memWrite; // store keeps its own MDR
                    nextState  = stateT2;
                end
            end
            stateT2: begin
                if (!memAck) begin
                    if (memWrite) begin
                        nextState = stateT0;
                    end else begin
                        mdrOut    = 1'b1;
                        irIn      = 1'b1;
                        nextState = stateT3;
                    end
                end
            end
            stateT3: begin
                if (isAlu || isSt) begin
                    regSel    = irWord[rbMsb:rbLsb];
                    regOut    = 1'b1;
                    yIn       = 1'b1;
                    nextState = stateT4;
                end else if (opcode == opMfhi) begin
                    hiOut     = 1'b1;
                    regIn     = 1'b1;
                    nextState = stateT0;
                end else if (opcode == opMflo) begin
                    loOut     = 1'b1;
                    regIn     = 1'b1;
                    nextState = stateT0;
                end else if (opcode == opHalt) begin
                    nextState = stateHalted;
                end else begin
                    nextState = stateT0; // nop and unknown codes
                end
            end
            stateT4: begin
                if (isImm || isSt) begin
                    constOut = 1'b1;
                end else begin
                    regSel = irWord[rcMsb:rcLsb];
                    regOut = 1'b1;
                end
                aluOp     = isSt ? opAdd : opcode; // st forms rb + constant
                zIn       = 1'b1;
                nextState = stateT5;
            end
            stateT5: begin
                zLowOut = 1'b1;
                if (isSt) begin
                    marIn     = 1'b1;
                    nextState = stateT6;
                end else if (isWide) begin
                    loIn      = 1'b1;
                    nextState = stateT6;
                end else begin
                    regIn     = 1'b1;
                    nextState = stateT0;
                end
            end
            stateT6: begin
                if (isSt) begin
                    regOut    = 1'b1;
                    mdrIn     = 1'b1;
                    nextState = stateFetchWait;
                end else begin
                    zHighOut  = 1'b1;
                    hiIn      = 1'b1;
                    nextState = stateT0;
                end
            end
            stateHalted: nextState = stateHalted;
            default:     nextState = stateT0;
        endcase
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            state    <= stateT0;
            memReq   <= 1'b0;
            memWrite <= 1'b0;
            halted   <= 1'b0;
        end else begin
            state <= nextState;
            if (state == stateT1) begin
                memReq <= 1'b1; // fetch read, MAR set in T0
            end
            if (state == stateT6 && isSt) begin
                memReq   <= 1'b1;
                memWrite <= 1'b1;
            end
            if (state == stateFetchWait && memAck) begin
                memReq <= 1'b0;
            end
            if (state == stateT2 && !memAck) begin
                memWrite <= 1'b0; // port idle again
            end
            if (state == stateT3 && opcode == opHalt) begin
                halted <= 1'b1;
            end
        end
    end

endmodule

/* source/cpuCore.sv */
`timescale 1ns/1ps

module cpuCore
    import cpuPkg::*;
(
    input  logic                 clock,
    input  logic                 rstN,
    output logic                 memReq,
    output logic                 memWrite,
    output logic [wordWidth-1:0] memAddr,
    output logic [wordWidth-1:0] memWriteData,
    input  logic [wordWidth-1:0] memReadData,
    input  logic                 memAck,
    output logic                 halted
);

    logic pcOut, mdrOut, zLowOut, zHighOut, hiOut, loOut, regOut, constOut;
    logic pcIn, marIn, mdrIn, irIn, yIn, zIn, regIn, hiIn, loIn;
    logic incPc;
    logic memCapture;
    logic [opWidth-1:0]     aluOp;
    logic [regSelWidth-1:0] regSel;
    logic [wordWidth-1:0]   irWord;

    controlSequencer i_sequencer (
        .clock(clock), .rstN(rstN), .irWord(irWord), .memAck(memAck),
        .pcOut(pcOut), .mdrOut(mdrOut), .zLowOut(zLowOut), .zHighOut(zHighOut),
        .hiOut(hiOut), .loOut(loOut), .regOut(regOut), .constOut(constOut),
        .pcIn(pcIn), .marIn(marIn), .mdrIn(mdrIn), .irIn(irIn), .yIn(yIn),
        .zIn(zIn), .regIn(regIn), .hiIn(hiIn), .loIn(loIn), .incPc(incPc),
        .aluOp(aluOp), .memCapture(memCapture), .regSel(regSel),
        .memReq(memReq), .memWrite(memWrite), .halted(halted)
    );

    datapath i_datapath (
        .clock(clock), .rstN(rstN),
        .pcOut(pcOut), .mdrOut(mdrOut), .zLowOut(zLowOut), .zHighOut(zHighOut),
        .hiOut(hiOut), .loOut(loOut), .regOut(regOut), .constOut(constOut),
        .pcIn(pcIn), .marIn(marIn), .mdrIn(mdrIn), .irIn(irIn), .yIn(yIn),
        .zIn(zIn), .regIn(regIn), .hiIn(hiIn), .loIn(loIn), .incPc(incPc),
        .aluOp(aluOp), .memCapture(memCapture), .regSel(regSel),
        .memReadData(memReadData), .irWord(irWord),
        .marValue(memAddr), .mdrValue(memWriteData) // MAR and MDR face the port
    );

endmodule

/* source/cpuPkg.sv */
package cpuPkg;

    // datapath sizes
    localparam int wordWidth   = 32;
    localparam int regCount    = 16;
    localparam int regSelWidth = 4;
    localparam int opWidth     = 5;
    localparam int stateWidth  = 4;

    // instruction fields
    localparam int opMsb      = 31;
    localparam int opLsb      = 27;
    localparam int raMsb      = 26;
    localparam int raLsb      = 23;
    localparam int rbMsb      = 22;
    localparam int rbLsb      = 19;
    localparam int rcMsb      = 18;
    localparam int rcLsb      = 15;
    localparam int constWidth = 15; // bits 14..0, sign-extended

    // opcodes
    localparam logic [opWidth-1:0] opSt   = 5'b00010;
    localparam logic [opWidth-1:0] opAdd  = 5'b00011;
    localparam logic [opWidth-1:0] opSub  = 5'b00100;
    localparam logic [opWidth-1:0] opAnd  = 5'b00101;
    localparam logic [opWidth-1:0] opOr   = 5'b00110;
    localparam logic [opWidth-1:0] opAddi = 5'b01000;
    localparam logic [opWidth-1:0] opNop  = 5'b01101;
    localparam logic [opWidth-1:0] opMul  = 5'b01111;
    localparam logic [opWidth-1:0] opDiv  = 5'b10000;
    localparam logic [opWidth-1:0] opMfhi = 5'b10100;
    localparam logic [opWidth-1:0] opMflo = 5'b10101;
    localparam logic [opWidth-1:0] opHalt = 5'b11010;

    // sequencer states
    localparam logic [stateWidth-1:0] stateT0        = 4'd0;
    localparam logic [stateWidth-1:0] stateT1        = 4'd1;
    localparam logic [stateWidth-1:0] stateT2        = 4'd2;
    localparam logic [stateWidth-1:0] stateT3        = 4'd3;
    localparam logic [stateWidth-1:0] stateT4        = 4'd4;
    localparam logic [stateWidth-1:0] stateT5        = 4'd5;
    localparam logic [stateWidth-1:0] stateT6        = 4'd6;
    localparam logic [stateWidth-1:0] stateFetchWait = 4'd7; // also the store wait
    localparam logic [stateWidth-1:0] stateHalted    = 4'd8;

    localparam logic [wordWidth-1:0] resetPc = 32'h0000_0000;

endpackage

/* source/datapath.sv */
`timescale 1ns/1ps

module datapath
    import cpuPkg::*;
(
    input  logic                   clock,
    input  logic                   rstN,
    input  logic                   pcOut,
    input  logic                   mdrOut,
    input  logic                   zLowOut,
    input  logic                   zHighOut,
    input  logic                   hiOut,
    input  logic                   loOut,
    input  logic                   regOut,
    input  logic                   constOut,
    input  logic                   pcIn,
    input  logic                   marIn,
    input  logic                   mdrIn,
    input  logic                   irIn,
    input  logic                   yIn,
    input  logic                   zIn,
    input  logic                   regIn,
    input  logic                   hiIn,
    input  logic                   loIn,
    input  logic                   incPc,
    input  logic [opWidth-1:0]     aluOp,
    input  logic                   memCapture,
    input  logic [regSelWidth-1:0] regSel,
    input  logic [wordWidth-1:0]   memReadData,
    output logic [wordWidth-1:0]   irWord,
    output logic [wordWidth-1:0]   marValue,
    output logic [wordWidth-1:0]   mdrValue
);

    logic [wordWidth-1:0]   busValue;
    logic [wordWidth-1:0]   pcValue;
    logic [wordWidth-1:0]   irValue;
    logic [wordWidth-1:0]   yValue;
    logic [2*wordWidth-1:0] zValue;
    logic [2*wordWidth-1:0] aluResult;
    logic [wordWidth-1:0]   regData;
    logic [wordWidth-1:0]   hiData;
    logic [wordWidth-1:0]   loData;
    logic [wordWidth-1:0]   constValue;

    assign constValue = {{(wordWidth-constWidth){irValue[constWidth-1]}},
                         irValue[constWidth-1:0]};

    // single bus, sequencer keeps sources one-hot
    always_comb begin
        if (pcOut)         busValue = pcValue;
        else if (mdrOut)   busValue = mdrValue;
        else if (zLowOut)  busValue = zValue[wordWidth-1:0];
        else if (zHighOut) busValue = zValue[2*wordWidth-1:wordWidth];
        else if (hiOut)    busValue = hiData;
        else if (loOut)    busValue = loData;
        else if (regOut)   busValue = regData;
        else if (constOut) busValue = constValue;
        else               busValue = '0;
    end

    always_ff @(posedge clock) begin
        if (!rstN) begin
            pcValue  <= resetPc;
            marValue <= '0;
            mdrValue <= '0;
            irValue  <= '0;
            yValue   <= '0;
            zValue   <= '0;
        end else begin
            if (pcIn)  pcValue  <= busValue;
            if (marIn) marValue <= busValue;
            if (memCapture) begin
                mdrValue <= memReadData; // read data from the port
            end else if (mdrIn) begin
                mdrValue <= busValue;
            end
            if (irIn) irValue <= busValue;
            if (yIn)  yValue  <= busValue;
            if (zIn)  zValue  <= aluResult;
        end
    end

    assign irWord = irValue;

    registerFile i_registerFile (
        .clock   (clock),
        .rstN    (rstN),
        .regSel  (regSel),
        .regIn   (regIn),
        .regOut  (regOut),
        .hiIn    (hiIn),
        .loIn    (loIn),
        .busIn   (busValue),
        .regData (regData),
        .hiData  (hiData),
        .loData  (loData)
    );

    arithUnit i_arithUnit (
        .yValue   (yValue),
        .busValue (busValue),
        .aluOp    (aluOp),
        .incPc    (incPc),
        .result   (aluResult)
    );

endmodule

/* source/registerFile.sv */
`timescale 1ns/1ps

module registerFile
    import cpuPkg::*;
(
    input  logic                   clock,
    input  logic                   rstN,
    input  logic [regSelWidth-1:0] regSel,
    input  logic                   regIn,
    input  logic                   regOut,
    input  logic                   hiIn,
    input  logic                   loIn,
    input  logic [wordWidth-1:0]   busIn,
    output logic [wordWidth-1:0]   regData,
    output logic [wordWidth-1:0]   hiData,
    output logic [wordWidth-1:0]   loData
);

    logic [wordWidth-1:0] regs [regCount];
    logic [wordWidth-1:0] hiReg;
    logic [wordWidth-1:0] loReg;

    always_ff @(posedge clock) begin
        if (!rstN) begin
            for (int i = 0; i < regCount; i++) begin
                regs[i] <= '0;
            end
            hiReg <= '0;
            loReg <= '0;
        end else begin
            if (regIn && regSel != '0) begin // r0 is hardwired zero
                regs[regSel] <= busIn;
            end
            if (hiIn) hiReg <= busIn;
            if (loIn) loReg <= busIn;
        end
    end

    // read port only drives a value while selected onto the bus
    assign regData = (regOut && regSel != '0) ? regs[regSel] : '0;
    assign hiData  = hiReg;
    assign loData  = loReg;

endmodule

/* test/cpuCoreTb.sv */
`timescale 1ns/1ps

module cpuCoreTb
    import cpuPkg::*;
();

    localparam int memWords   = 1024;
    localparam int resultBase = 512; // stores land here, program sits below
    localparam int mixCount   = 40;

    logic                 clock = 1'b0;
    logic                 rstN = 1'b0;
    logic                 memReq;
    logic                 memWrite;
    logic [wordWidth-1:0] memAddr;
    logic [wordWidth-1:0] memWriteData;
    logic [wordWidth-1:0] memReadData = '0;
    logic                 memAck = 1'b0;
    logic                 halted;

    logic [wordWidth-1:0] memArray [memWords];
    logic [wordWidth-1:0] lcgState = 32'h53f0_4274;
    logic [wordWidth-1:0] modelRegs [regCount];
    logic [wordWidth-1:0] modelHi;
    logic [wordWidth-1:0] modelLo;
    logic [wordWidth-1:0] expAddr [$];
    logic [wordWidth-1:0] expData [$];
    logic [wordWidth-1:0] fetchPc = resetPc;
    logic [wordWidth-1:0] prevAddr = '0;
    logic                 prevReq = 1'b0;
    logic                 prevAck = 1'b0;
    logic                 prevWrite = 1'b0;
    int                   progLen;
    int                   storeCount;
    int                   ackWait = 0;
    int                   cycleCount = 0;
    int                   cycleLimit = 1000000; // replaced once the program is known

    cpuCore i_dut (
        .clock        (clock),
        .rstN         (rstN),
        .memReq       (memReq),
        .memWrite     (memWrite),
        .memAddr      (memAddr),
        .memWriteData (memWriteData),
        .memReadData  (memReadData),
        .memAck       (memAck),
        .halted       (halted)
    );

    always #4 clock = ~clock;

    function automatic logic [wordWidth-1:0] nextRandom();
        lcgState = lcgState * 32'd1664525 + 32'd1013904223;
        return lcgState;
    endfunction

    function automatic int pick(int n);
        return int'(nextRandom() >> 16) % n; // upper bits, low ones cycle fast
    endfunction

    task automatic compareValue(string name, logic [wordWidth-1:0] actual,
                                logic [wordWidth-1:0] expected);
        if (actual !== expected) begin
            $display("mismatch at %0t: %s is %h, expected %h", $time, name, actual, expected);
            $display("Test FAILED");
            $fatal(1, "stopped at first error");
        end
    endtask

    function automatic logic [opWidth-1:0] kindOpcode(int kind);
        case (kind)
            0: return opAdd;
            1: return opSub;
            2: return opAnd;
            3: return opOr;
            4: return opAddi;
            5: return opMul;
            6: return opDiv;
            7: return opMfhi;
            default: return opMflo;
        endcase
    endfunction

    task automatic emit(logic [opWidth-1:0] op, int ra, int rb, int rc, logic [14:0] k);
        memArray[progLen] = {op, 4'(ra), 4'(rb), 4'(rc), k};
        progLen++;
    endtask

    task automatic writeReg(int ra, logic [wordWidth-1:0] value);
        if (ra != 0) modelRegs[ra] = value; // r0 stays zero
    endtask

    task automatic storeReg(int ra);
        emit(opSt, ra, 0, 0, 15'(resultBase + storeCount)); // address r0 + constant
        expAddr.push_back(resultBase + storeCount);
        expData.push_back(modelRegs[ra]);
        storeCount++;
    endtask

    task automatic moveAndStore(logic [opWidth-1:0] op, int ra);
        emit(op, ra, 0, 0, '0);
        writeReg(ra, (op == opMfhi) ? modelHi : modelLo);
        storeReg(ra);
    endtask

    task automatic buildProgram();
        int                            kind;
        int                            ra;
        int                            rb;
        int                            rc;
        logic [14:0]                   k;
        logic signed [wordWidth-1:0]   a;
        logic signed [wordWidth-1:0]   b;
        logic signed [2*wordWidth-1:0] prod;
        logic [wordWidth-1:0]          value;
        for (int i = 0; i < memWords; i++) begin
            memArray[i] = 32'hc3a5_0000 ^ (i * 32'h0001_0001);
        end
        for (int r = 0; r < regCount; r++) begin
            modelRegs[r] = '0;
        end
        modelHi = '0;
        modelLo = '0;
        progLen = 0;
        storeCount = 0;
        // load r1..r15 with random signed constants
        for (int r = 1; r < regCount; r++) begin
            k = 15'(nextRandom() >> 9);
            emit(opAddi, r, 0, 0, k);
            writeReg(r, {{17{k[14]}}, k});
            storeReg(r);
        end
        for (int i = 0; i < mixCount; i++) begin
            kind = (i < 2) ? 5 + i : pick(9); // first a mul, then a div by r0
            ra = pick(regCount);
            rb = pick(regCount);
            rc = (kind == 6 && (i == 1 || pick(3) == 0)) ? 0 : pick(regCount);
            k = 15'(nextRandom() >> 9);
            a = modelRegs[rb];
            b = modelRegs[rc];
            if (kind == 6 && a == 32'h8000_0000 && b == '1) begin
                rc = 0; // steer clear of the one overflowing quotient
                b = '0;
            end
            emit(kindOpcode(kind), ra, rb, rc, k);
            value = '0;
            case (kind)
                0: value = a + b;
                1: value = a - b;
                2: value = a & b;
                3: value = a | b;
                4: value = a + {{17{k[14]}}, k};
                5: begin
                    prod = a * b; // signed operands, 64-bit context
                    {modelHi, modelLo} = prod;
                end
                6: begin
                    if (b == 0) begin
                        modelLo = '1;
                        modelHi = a;
                    end else begin
                        modelLo = a / b;
                        modelHi = a % b;
                    end
                end
                7: value = modelHi;
                default: value = modelLo;
            endcase
            if (kind == 5) begin
                moveAndStore(opMfhi, ra);
                moveAndStore(opMflo, rb);
            end else if (kind == 6) begin
                moveAndStore(opMflo, ra);
                moveAndStore(opMfhi, rb);
            end else begin
                writeReg(ra, value);
                storeReg(ra);
            end
        end
        emit(opHalt, 0, 0, 0, '0);
    endtask

    // memory side of the four-phase port, 0 to 3 cycles each way
    always @(posedge clock) begin
        if (!rstN) begin
            memAck  <= 1'b0;
            ackWait <= pick(4);
        end else if (!memAck && memReq) begin
            if (ackWait > 0) begin
                ackWait <= ackWait - 1;
            end else begin
                if (memWrite) begin
                    if (expAddr.size() == 0) begin
                        $display("store to %h after the last expected store", memAddr);
                        $display("Test FAILED");
                        $fatal(1, "unexpected store");
                    end
                    compareValue("store memAddr", memAddr, expAddr.pop_front());
                    compareValue("store memWriteData", memWriteData, expData.pop_front());
                    memArray[memAddr % memWords] = memWriteData;
                end else begin
                    compareValue("fetch memAddr", memAddr, fetchPc); // no branches
                    fetchPc     <= fetchPc + 1;
                    memReadData <= memArray[memAddr % memWords];
                end
                memAck  <= 1'b1;
                ackWait <= pick(4);
            end
        end else if (memAck && !memReq) begin
            if (ackWait > 0) begin
                ackWait <= ackWait - 1;
            end else begin
                memAck  <= 1'b0;
                ackWait <= pick(4);
            end
        end
    end

    // protocol watch on the port
    always @(posedge clock) begin
        if (rstN) begin
            if (prevReq && memReq) begin
                compareValue("memAddr while memReq high", memAddr, prevAddr);
                compareValue("memWrite while memReq high", memWrite, prevWrite);
            end
            if (prevReq && !memReq) compareValue("memAck as memReq fell", prevAck, 1'b1);
            if (!prevReq && memReq) compareValue("memAck as memReq rose", prevAck, 1'b0);
        end
        prevReq   <= memReq;
        prevAck   <= memAck;
        prevWrite <= memWrite;
        prevAddr  <= memAddr;
    end

    always @(posedge clock) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("timeout: halted never rose within %0d cycles", cycleLimit);
            $display("Test FAILED");
            $fatal(1, "run timed out");
        end
    end

    initial begin
        buildProgram();
        cycleLimit = progLen * 40;
        repeat (3) @(posedge clock);
        rstN <= 1'b1;
        @(posedge clock);
        compareValue("memReq after reset", memReq, 1'b0);
        compareValue("halted after reset", halted, 1'b0);
        while (!halted) @(posedge clock);
        repeat (20) begin
            @(posedge clock);
            compareValue("memReq after halt", memReq, 1'b0);
            compareValue("halted after halt", halted, 1'b1);
        end
        compareValue("words fetched", fetchPc, progLen); // halt is the last fetch
        if (expAddr.size() != 0) begin
            $display("%0d expected stores never reached the port", expAddr.size());
            $display("Test FAILED");
            $fatal(1, "missing stores");
        end else begin
            $display("Test OK");
            $finish;
        end
    end

endmodule
